/* fp_mul_macros.svh */
/*
 * Single-precision multiplier constants
 * Field widths, exponent bias, product width and pipeline depth
 */

`ifndef FP_MUL_MACROS_SVH
`define FP_MUL_MACROS_SVH

// IEEE 754 binary32 fields
`define FP_EXP_WIDTH 8
`define FP_SIG_WIDTH 23
`define FP_WIDTH 32
`define FP_EXP_BIAS 127

// 32-bit multiplier times 24-bit multiplicand, sized for ITOF
`define FP_PRODUCT_WIDTH 56

// Register stages from op_valid to result_valid
`define FP_MUL_LATENCY 3

`endif

/* fp_format_pkg.sv */
/*
 * Number format and operation types
 */

`include "fp_mul_macros.svh"

`default_nettype none

package fp_format_pkg;

	// Opcodes handled by the multiply unit
	typedef enum logic [5:0]
	{
		OP_FMUL = 6'b100010,	// Float times float
		OP_ITOF = 6'b101010		// Signed integer in operand2 to float
	} fp_op_t;

	// One single-precision word, MSB first
	typedef struct packed
	{
		logic sign;
		logic [`FP_EXP_WIDTH-1:0] exponent;
		logic [`FP_SIG_WIDTH-1:0] significand;
	} fp_word_t;

endpackage

`default_nettype wire

/* fp_pipe_pkg.sv */
/*
 * Inter-stage records of the multiply pipeline
 */

`include "fp_mul_macros.svh"

`default_nettype none

package fp_pipe_pkg;

	// Stage 1 to stage 2
	typedef struct packed
	{
		logic valid;
		logic sign;
		// Biased sum, may go negative or past 255 before normalization
		logic signed [`FP_EXP_WIDTH+1:0] exponent;
		logic [`FP_SIG_WIDTH:0] multiplicand;	// Hidden bit included
		logic [`FP_WIDTH-1:0] multiplier;		// Significand or integer magnitude
	} mul_stage1_t;

	// Stage 2 to stage 3
	typedef struct packed
	{
		logic valid;
		logic sign;
		logic signed [`FP_EXP_WIDTH+1:0] exponent;
		logic [`FP_PRODUCT_WIDTH-1:0] product;	// Unnormalized, zero means zero result
	} mul_stage2_t;

endpackage

`default_nettype wire

/* fp_multiplier_stage1.sv */
/*
 * Multiplier stage 1
 * Inserts hidden bits, forms the ITOF magnitude, computes sign and exponent sum
 */

`include "fp_mul_macros.svh"

`timescale 1ns/1ns
`default_nettype none

module fp_multiplier_stage1
	import fp_format_pkg::*;
	import fp_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic op_valid,
	input fp_op_t op,
	input fp_word_t operand1,
	input fp_word_t operand2,
	output mul_stage1_t stage1
);

	mul_stage1_t stage1_next;
	logic [`FP_WIDTH-1:0] int_bits;
	logic [`FP_WIDTH-1:0] int_magnitude;
	logic [`FP_EXP_WIDTH+1:0] exp1_ext;
	logic [`FP_EXP_WIDTH+1:0] exp2_ext;

	// Operand2 seen as a two's complement integer
	assign int_bits = operand2;
	assign int_magnitude = int_bits[`FP_WIDTH-1] ? (~int_bits + 1'b1) : int_bits;

	// Zero-extend exponents so the signed sum cannot wrap
	assign exp1_ext = {2'b00, operand1.exponent};
	assign exp2_ext = {2'b00, operand2.exponent};

	always_comb
	begin
		stage1_next.valid = op_valid;
		if (op == OP_ITOF)
		begin
			// Multiply the magnitude by 1.0
			stage1_next.sign = operand2.sign;
			stage1_next.multiplicand = 1 << `FP_SIG_WIDTH;
			stage1_next.multiplier = int_magnitude;
			// Integer point sits 23 bits below the implied binary point
			stage1_next.exponent = `FP_EXP_BIAS + `FP_SIG_WIDTH;
		end
		else
		begin
			stage1_next.sign = operand1.sign ^ operand2.sign;
			// Zero exponent flushes the whole significand
			if (operand1.exponent != '0)
				stage1_next.multiplicand = {1'b1, operand1.significand};
			else
				stage1_next.multiplicand = '0;
			if (operand2.exponent != '0)
				stage1_next.multiplier = {8'd0, 1'b1, operand2.significand};
			else
				stage1_next.multiplier = '0;
			stage1_next.exponent = $signed(exp1_ext) + $signed(exp2_ext) - `FP_EXP_BIAS;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			stage1 <= '0;
		else
			stage1 <= stage1_next;
	end

endmodule

`default_nettype wire

/* fp_multiplier_stage2.sv */
/*
 * Multiplier stage 2
 * Registered significand product
 */

`timescale 1ns/1ns
`default_nettype none

module fp_multiplier_stage2
	import fp_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input mul_stage1_t stage1,
	output mul_stage2_t stage2
);

	mul_stage2_t stage2_next;

	always_comb
	begin
		stage2_next.valid = stage1.valid;
		stage2_next.sign = stage1.sign;
		stage2_next.exponent = stage1.exponent;
		// 24 x 32 bits, full width kept, no rounding here
		// A flushed operand gives a zero product
		stage2_next.product = stage1.multiplicand * stage1.multiplier;
	end

	// Pipeline register
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			stage2 <= '0;
		end
		else
		begin
			stage2 <= stage2_next;
		end
	end

endmodule

`default_nettype wire

/* fp_multiplier_stage3.sv */
/*
 * Multiplier stage 3
 * Leading-one search, normalization, truncation, range check and packing
 */

`include "fp_mul_macros.svh"

`timescale 1ns/1ns
`default_nettype none

module fp_multiplier_stage3
	import fp_format_pkg::*;
	import fp_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input mul_stage2_t stage2,
	output logic result_valid,
	output fp_word_t result,
	output logic overflow,
	output logic underflow
);

	logic [5:0] lead_pos;
	logic product_nonzero;
	logic [`FP_PRODUCT_WIDTH-1:0] normalized;
	logic signed [`FP_EXP_WIDTH+2:0] exp_final;
	fp_word_t result_next;
	logic overflow_next;
	logic underflow_next;

	// Priority encoder, highest set bit wins
	always_comb
	begin
		lead_pos = '0;
		for (int i = 0; i < `FP_PRODUCT_WIDTH; i++)
		begin
			if (stage2.product[i])
				lead_pos = i[5:0];
		end
	end

	assign product_nonzero = |stage2.product;

	// Move the leading one to the top bit
	assign normalized = stage2.product << (`FP_PRODUCT_WIDTH - 1 - lead_pos);

	// 1.x times 1.y puts the binary point below bit 46
	assign exp_final = stage2.exponent + $signed({5'b00000, lead_pos})
		- 2 * `FP_SIG_WIDTH;

	always_comb
	begin
		result_next.sign = stage2.sign;
		result_next.exponent = exp_final[`FP_EXP_WIDTH-1:0];
		// Bits below the leading one, rest dropped
		result_next.significand = normalized[`FP_PRODUCT_WIDTH-2 -: `FP_SIG_WIDTH];
		overflow_next = 1'b0;
		underflow_next = 1'b0;
		if (!product_nonzero)
		begin
			// Signed zero, no flags
			result_next.exponent = '0;
			result_next.significand = '0;
		end
		else if (exp_final >= 255)
		begin
			// Saturate to infinity
			result_next.exponent = '1;
			result_next.significand = '0;
			overflow_next = 1'b1;
		end
		else if (exp_final <= 0)
		begin
			// Subnormal range flushed
			result_next.exponent = '0;
			result_next.significand = '0;
			underflow_next = 1'b1;
		end
	end

	// Outputs hold between valid items
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			result_valid <= 1'b0;
			result <= '0;
			overflow <= 1'b0;
			underflow <= 1'b0;
		end
		else
		begin
			result_valid <= stage2.valid;
			if (stage2.valid)
			begin
				result <= result_next;
				overflow <= overflow_next;
				underflow <= underflow_next;
			end
		end
	end

endmodule

`default_nettype wire

/* fp_multiplier.sv */
/*
 * Floating-point multiply unit, three stages
 * FMUL and ITOF, one item per cycle, no stall
 */

`timescale 1ns/1ns
`default_nettype none

module fp_multiplier
	import fp_format_pkg::*;
	import fp_pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic op_valid,
	input fp_op_t op,
	input fp_word_t operand1,
	input fp_word_t operand2,
	output logic result_valid,
	output fp_word_t result,
	output logic overflow,
	output logic underflow
);

	// Pipeline registers between stages
	mul_stage1_t stage1_data;
	mul_stage2_t stage2_data;

	// Operand prep and exponent sum
	fp_multiplier_stage1 stage1_i (
		.clk (clk),
		.reset (reset),
		.op_valid (op_valid),
		.op (op),
		.operand1 (operand1),
		.operand2 (operand2),
		.stage1 (stage1_data)
	);

	// Significand product
	fp_multiplier_stage2 stage2_i (
		.clk (clk),
		.reset (reset),
		.stage1 (stage1_data),
		.stage2 (stage2_data)
	);

	// Normalize and pack
	fp_multiplier_stage3 stage3_i (
		.clk (clk),
		.reset (reset),
		.stage2 (stage2_data),
		.result_valid (result_valid),
		.result (result),
		.overflow (overflow),
		.underflow (underflow)
	);

endmodule

`default_nettype wire

/* fp_multiplier_assertions.sv */
/*
 * Bound checks on the multiply unit's valid pipeline and range flags
 */

`include "fp_mul_macros.svh"

`timescale 1ns/1ns
`default_nettype none

module fp_multiplier_assertions (
	input logic clk,
	input logic reset,
	input logic op_valid,
	input logic result_valid,
	input logic overflow,
	input logic underflow
);

	int failure_count = 0;

	// Each accepted item leaves the last stage a fixed latency later
	latency_a: assert property (@(posedge clk) disable iff (reset)
		result_valid == $past(op_valid, `FP_MUL_LATENCY))
	else
	begin
		failure_count++;
		$error("result_valid does not follow op_valid by the pipeline latency");
	end

	// Infinity and flushed zero exclude each other
	exclusive_flags_a: assert property (@(posedge clk) !(overflow && underflow))
	else
	begin
		failure_count++;
		$error("overflow and underflow high together");
	end

	reset_flags_a: assert property (@(posedge clk) reset |-> (!overflow && !underflow))
	else
	begin
		failure_count++;
		$error("range flag high during reset");
	end

endmodule

bind fp_multiplier fp_multiplier_assertions assertions_i (.*);

`default_nettype wire

/* fp_multiplier_tb.sv */
/*
 * Testbench for the floating-point multiply unit
 * Directed and random FMUL/ITOF items checked in order against a reference model
 */

`include "fp_mul_macros.svh"

`timescale 1ns/1ns
`default_nettype none

module fp_multiplier_tb
	import fp_format_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int RANDOM_SEED = 24239;
	localparam int DIRECTED_COUNT = 11;
	localparam int RANDOM_COUNT = 300;
	localparam int GAP_COUNT = 100;
	localparam int MAX_GAP = 4;
	localparam int DRAIN_CYCLES = 20;
	// Every item plus its worst-case gap, both drains and some slack
	localparam int TIMEOUT_CYCLES = DIRECTED_COUNT + RANDOM_COUNT
		+ GAP_COUNT * (MAX_GAP + 1) + 2 * DRAIN_CYCLES + 50;

	logic clk;
	logic reset;
	logic op_valid;
	fp_op_t op;
	fp_word_t operand1;
	fp_word_t operand2;
	logic result_valid;
	fp_word_t result;
	logic overflow;
	logic underflow;

	// Expected {overflow, underflow, result}, name and issue cycle per item
	logic [33:0] expected_queue[$];
	string name_queue[$];
	int issue_queue[$];

	int cycle_count = 0;
	int mismatch_errors = 0;
	int protocol_errors = 0;
	logic [33:0] expected_bits;
	string expected_name;
	int issue_cycle;

	fp_multiplier dut_i (
		.clk (clk),
		.reset (reset),
		.op_valid (op_valid),
		.op (op),
		.operand1 (operand1),
		.operand2 (operand2),
		.result_valid (result_valid),
		.result (result),
		.overflow (overflow),
		.underflow (underflow)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// Highest set bit or -1 for zero
	function automatic int leading_one(input longint unsigned value);
		int pos;
		pos = -1;
		for (int i = 0; i < 64; i++)
		begin
			if (value[i])
				pos = i;
		end
		return pos;
	endfunction

	// Expected {overflow, underflow, result} from the format rules
	function automatic logic [33:0] fp_mul_ref(input fp_op_t item_op,
		input logic [31:0] a, input logic [31:0] b);
		longint unsigned value;
		int lead;
		int exp_val;
		logic sign;
		if (item_op == OP_ITOF)
		begin
			value = {32'd0, b};
			if (b[31])
				value = 64'h1_0000_0000 - value;
			if (value == 0)
				return 34'd0;
			sign = b[31];
			lead = leading_one(value);
			exp_val = 127 + lead;
			// Left-align short magnitudes and truncate long ones
			if (lead >= 23)
				value = value >> (lead - 23);
			else
				value = value << (23 - lead);
			return {2'b00, sign, exp_val[7:0], value[22:0]};
		end
		sign = a[31] ^ b[31];
		if (a[30:23] == 8'd0 || b[30:23] == 8'd0)
			return {2'b00, sign, 31'd0};
		value = {40'd0, 1'b1, a[22:0]} * {40'd0, 1'b1, b[22:0]};
		lead = leading_one(value);
		exp_val = int'(a[30:23]) + int'(b[30:23]) - 127 + lead - 46;
		if (exp_val >= 255)
			return {2'b10, sign, 8'hff, 23'd0};
		if (exp_val <= 0)
			return {2'b01, sign, 31'd0};
		value = value >> (lead - 23);
		return {2'b00, sign, exp_val[7:0], value[22:0]};
	endfunction

	// Mostly mid-range exponents and now and then any exponent at all
	function automatic logic [31:0] random_float();
		logic [31:0] word;
		word = $urandom;
		if ($urandom_range(7) != 0)
			word[30:23] = 8'(96 + $urandom_range(63));
		return word;
	endfunction

	// Drive one item on the falling edge and record what it should produce
	task automatic issue_item(input string name, input fp_op_t item_op,
		input logic [31:0] a, input logic [31:0] b);
		@(negedge clk);
		op_valid = 1'b1;
		op = item_op;
		operand1 = a;
		operand2 = b;
		expected_queue.push_back(fp_mul_ref(item_op, a, b));
		name_queue.push_back(name);
		issue_queue.push_back(cycle_count);
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			@(negedge clk);
			op_valid = 1'b0;
		end
	endtask

	// Wait until every issued item has come back, bounded
	task automatic drain_results();
		for (int k = 0; k < DRAIN_CYCLES && expected_queue.size() != 0; k++)
			@(negedge clk);
	endtask

	task automatic random_item(input string name);
		logic [31:0] word;
		if ($urandom_range(1) == 0)
		begin
			issue_item(name, OP_FMUL, random_float(), random_float());
		end
		else
		begin
			// Arithmetic shift spreads the integer magnitudes
			word = $signed($urandom) >>> $urandom_range(31);
			issue_item(name, OP_ITOF, $urandom, word);
		end
	endtask

	// Compare in issue order once outputs have settled
	always @(negedge clk)
	begin
		if (result_valid)
		begin
			if (expected_queue.size() == 0)
			begin
				$display("unexpected result at cycle %0d with no item outstanding", cycle_count);
				protocol_errors++;
			end
			else
			begin
				expected_bits = expected_queue.pop_front();
				expected_name = name_queue.pop_front();
				issue_cycle = issue_queue.pop_front();
				if (cycle_count != issue_cycle + `FP_MUL_LATENCY)
				begin
					$display("latency wrong for %s: issued at cycle %0d, result at cycle %0d",
						expected_name, issue_cycle, cycle_count);
					protocol_errors++;
				end
				if ({overflow, underflow, result} != expected_bits)
				begin
					$display("mismatch %s: expected %h ovf %b unf %b, actual %h ovf %b unf %b",
						expected_name, expected_bits[31:0], expected_bits[33],
						expected_bits[32], result, overflow, underflow);
					mismatch_errors++;
				end
			end
		end
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(RANDOM_SEED));
		clk = 1'b0;
		reset = 1'b1;
		op_valid = 1'b0;
		op = OP_FMUL;
		operand1 = '0;
		operand2 = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		// Directed multiplies, signed zero, overflow and underflow
		issue_item("fmul 1.5x2.0", OP_FMUL, 32'h3fc00000, 32'h40000000);
		issue_item("fmul -3.0x0.5", OP_FMUL, 32'hc0400000, 32'h3f000000);
		issue_item("fmul by zero", OP_FMUL, 32'hc0200000, 32'h00000000);
		issue_item("fmul overflow", OP_FMUL, 32'h7f000000, 32'h7f000000);
		issue_item("fmul underflow", OP_FMUL, 32'h80800000, 32'h00800000);
		idle_cycles(1);
		drain_results();

		// Reset again while the underflow flag is still held
		reset = 1'b1;
		idle_cycles(2);
		if ({result_valid, overflow, underflow, result} != 35'd0)
		begin
			$display("mismatch reset state: expected %h, actual %h", 35'd0,
				{result_valid, overflow, underflow, result});
			mismatch_errors++;
		end
		reset = 1'b0;

		// Integer conversions
		issue_item("itof 0", OP_ITOF, 32'h0, 32'h00000000);
		issue_item("itof 1", OP_ITOF, 32'h0, 32'h00000001);
		issue_item("itof -1", OP_ITOF, 32'h0, 32'hffffffff);
		issue_item("itof 255", OP_ITOF, 32'h0, 32'h000000ff);
		issue_item("itof 2^24+1", OP_ITOF, 32'h0, 32'h01000001);
		issue_item("itof -2^31", OP_ITOF, 32'h0, 32'h80000000);
		idle_cycles(2);

		// Back to back with three items in flight
		for (int i = 0; i < RANDOM_COUNT; i++)
			random_item($sformatf("random %0d", i));
		idle_cycles(1);

		// Random gaps between items
		for (int i = 0; i < GAP_COUNT; i++)
		begin
			random_item($sformatf("gapped %0d", i));
			idle_cycles(1 + $urandom_range(MAX_GAP - 1));
		end

		// Drain and then a few quiet cycles to catch stray results
		drain_results();
		idle_cycles(5);
		if (expected_queue.size() != 0)
		begin
			$display("%0d items never produced a result", expected_queue.size());
			protocol_errors++;
		end

		$display("errors: %0d mismatch, %0d protocol, %0d assertion", mismatch_errors,
			protocol_errors, dut_i.assertions_i.failure_count);
		if (mismatch_errors + protocol_errors + dut_i.assertions_i.failure_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
fp_format_pkg.sv
fp_pipe_pkg.sv
fp_multiplier_stage1.sv
fp_multiplier_stage2.sv
fp_multiplier_stage3.sv
fp_multiplier.sv
fp_multiplier_assertions.sv
fp_multiplier_tb.sv

/* Bender.yml */
package:
  name: fp_multiplier

export_include_dirs:
  - .

sources:
  - fp_format_pkg.sv
  - fp_pipe_pkg.sv
  - fp_multiplier_stage1.sv
  - fp_multiplier_stage2.sv
  - fp_multiplier_stage3.sv
  - fp_multiplier.sv
  - target: simulation
    files:
      - fp_multiplier_assertions.sv
      - fp_multiplier_tb.sv
